// File: logic/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Operand and result width
`define EX_DATA_W   32

// Destination register address width
`define EX_ADDR_W   5

// Low bits of rs that give the shift amount
`define EX_SHAMT_W  5

// Operation code width
`define EX_OP_W     5

`endif

// File: logic/ex_pkg.sv
`include "ex_macros.svh"

package ex_pkg;

    // Execute operations in encoding order
    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,     // Traps on signed overflow
        OP_ADDU,
        OP_SUB,     // Traps on signed overflow
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MOVZ,    // Condition resolved upstream through wreg
        OP_MOVN,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MUL,     // Low product word to register
        OP_MULT,
        OP_MULTU
    } alu_op_e;

    // Result class of the write-back word
    typedef enum logic [2:0] {
        RES_NONE,
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_MOVE,
        RES_MUL
    } res_sel_e;

    typedef enum logic [1:0] {
        HILO_NONE,
        HILO_PRODUCT,   // Full 64-bit product
        HILO_HI,
        HILO_LO
    } hilo_wr_e;

endpackage

// File: logic/ex_decode.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_decode import ex_pkg::*; (
    input  alu_op_e  aluop_i,
    output res_sel_e res_sel_o,
    output alu_op_e  alu_fn_o,      // NOP unless the ALU result is used
    output logic     sub_en_o,
    output logic     cmp_signed_o,
    output logic     cnt_ones_o,
    output logic     ovf_trap_o,
    output logic     mul_signed_o,
    output logic     mf_hi_o,
    output logic     mf_lo_o,
    output hilo_wr_e hilo_wr_o
);

    logic known_op;

    // Only the first 25 codes are defined
    assign known_op = !$isunknown(aluop_i) && (aluop_i <= OP_MULTU);

    always_comb begin
        res_sel_o = RES_NONE;
        alu_fn_o  = OP_NOP;
        hilo_wr_o = HILO_NONE;
        case (aluop_i)
            OP_AND, OP_OR, OP_XOR, OP_NOR: begin
                res_sel_o = RES_LOGIC;
                alu_fn_o  = aluop_i;
            end
            OP_SLL, OP_SRL, OP_SRA: begin
                res_sel_o = RES_SHIFT;
                alu_fn_o  = aluop_i;
            end
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: begin
                res_sel_o = RES_ARITH;
                alu_fn_o  = aluop_i;
            end
            OP_MOVZ, OP_MOVN, OP_MFHI, OP_MFLO: res_sel_o = RES_MOVE;
            OP_MUL:   res_sel_o = RES_MUL;
            OP_MULT, OP_MULTU: hilo_wr_o = HILO_PRODUCT;
            OP_MTHI:  hilo_wr_o = HILO_HI;
            OP_MTLO:  hilo_wr_o = HILO_LO;
            default:  ;
        endcase

        // Every op that writes a register must carry a result class
        if (known_op && !(aluop_i inside {OP_NOP, OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU})) begin
            assert (res_sel_o != RES_NONE)
                else $error("ex_decode: no result class for op %0d", aluop_i);
        end
    end

    assign sub_en_o     = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) || (aluop_i == OP_SLT);
    assign cmp_signed_o = (aluop_i == OP_SLT);
    assign cnt_ones_o   = (aluop_i == OP_CLO);
    assign ovf_trap_o   = (aluop_i == OP_ADD) || (aluop_i == OP_SUB); // Unsigned forms never trap
    assign mul_signed_o = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);
    assign mf_hi_o      = (aluop_i == OP_MFHI);
    assign mf_lo_o      = (aluop_i == OP_MFLO);

endmodule

// File: logic/ex_alu.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
    input  alu_op_e                alu_fn_i,
    input  logic [`EX_DATA_W-1:0]  reg1_i,     // rs
    input  logic [`EX_DATA_W-1:0]  reg2_i,     // rt
    input  logic                   sub_en_i,
    input  logic                   cmp_signed_i,
    input  logic                   cnt_ones_i,
    output logic [`EX_DATA_W-1:0]  alu_res_o,
    output logic                   ovf_o
);

    logic [`EX_DATA_W-1:0]  reg2_mux;
    logic [`EX_DATA_W-1:0]  sum;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   reg1_lt_reg2;
    logic [`EX_DATA_W-1:0]  cnt_word;
    logic [`EX_DATA_W-1:0]  lead_cnt;

    assign shamt    = reg1_i[`EX_SHAMT_W-1:0];
    assign reg2_mux = sub_en_i ? -reg2_i : reg2_i;   // Two's complement for subtract
    assign sum      = reg1_i + reg2_mux;

    // Equal operand signs but a sum of the other sign
    assign ovf_o = (reg1_i[`EX_DATA_W-1] == reg2_mux[`EX_DATA_W-1]) &&
                   (sum[`EX_DATA_W-1] != reg1_i[`EX_DATA_W-1]);

    // Signed compare relies on sub_en being high for SLT
    always_comb begin
        if (cmp_signed_i) begin
            reg1_lt_reg2 = (reg1_i[`EX_DATA_W-1] && !reg2_i[`EX_DATA_W-1]) ||
                           ((reg1_i[`EX_DATA_W-1] == reg2_i[`EX_DATA_W-1]) &&
                            sum[`EX_DATA_W-1]);
        end else begin
            reg1_lt_reg2 = (reg1_i < reg2_i);
        end
    end

    // Leading ones become leading zeros after inversion
    assign cnt_word = cnt_ones_i ? ~reg1_i : reg1_i;

    always_comb begin
        lead_cnt = `EX_DATA_W;              // All zero word
        for (int i = 0; i < `EX_DATA_W; i++) begin
            if (cnt_word[i]) begin
                lead_cnt = `EX_DATA_W - 1 - i;  // Highest set bit wins
            end
        end
    end

    always_comb begin
        case (alu_fn_i)
            OP_AND:  alu_res_o = reg1_i & reg2_i;
            OP_OR:   alu_res_o = reg1_i | reg2_i;
            OP_XOR:  alu_res_o = reg1_i ^ reg2_i;
            OP_NOR:  alu_res_o = ~(reg1_i | reg2_i);
            OP_SLL:  alu_res_o = reg2_i << shamt;
            OP_SRL:  alu_res_o = reg2_i >> shamt;
            OP_SRA:  alu_res_o = $signed(reg2_i) >>> shamt;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                alu_res_o = sum;
            end
            OP_SLT, OP_SLTU: begin
                alu_res_o = {{(`EX_DATA_W-1){1'b0}}, reg1_lt_reg2};
            end
            OP_CLZ, OP_CLO: begin
                alu_res_o = lead_cnt;
            end
            default: alu_res_o = '0;
        endcase
    end

endmodule

// File: logic/ex_mul.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_mul (
    input  logic [`EX_DATA_W-1:0]    reg1_i,
    input  logic [`EX_DATA_W-1:0]    reg2_i,
    input  logic                     mul_signed_i,
    output logic [2*`EX_DATA_W-1:0]  product_o
);

    logic                    neg1;
    logic                    neg2;
    logic [`EX_DATA_W-1:0]   mag1;
    logic [`EX_DATA_W-1:0]   mag2;
    logic [2*`EX_DATA_W-1:0] mag_prod;

    // Sign bits only count for signed multiplies
    assign neg1 = mul_signed_i && reg1_i[`EX_DATA_W-1];
    assign neg2 = mul_signed_i && reg2_i[`EX_DATA_W-1];

    assign mag1 = neg1 ? -reg1_i : reg1_i;
    assign mag2 = neg2 ? -reg2_i : reg2_i;

    // Unsigned multiply of the magnitudes
    assign mag_prod = {{`EX_DATA_W{1'b0}}, mag1} * {{`EX_DATA_W{1'b0}}, mag2};

    // Negate back when the signs differ
    assign product_o = (neg1 ^ neg2) ? -mag_prod : mag_prod;

endmodule

// File: logic/ex_result.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_result import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  res_sel_e                 res_sel_i,
    input  logic [`EX_DATA_W-1:0]    alu_res_i,
    input  logic [2*`EX_DATA_W-1:0]  product_i,
    input  logic [`EX_DATA_W-1:0]    reg1_i,
    input  logic                     ovf_i,
    input  logic                     ovf_trap_i,
    input  hilo_wr_e                 hilo_wr_i,
    input  logic                     mf_hi_i,
    input  logic                     mf_lo_i,
    input  logic                     wreg_i,
    input  logic [`EX_ADDR_W-1:0]    waddr_i,
    output logic                     wreg_o,
    output logic [`EX_ADDR_W-1:0]    waddr_o,
    output logic [`EX_DATA_W-1:0]    wdata_o
);

    logic [`EX_DATA_W-1:0] hi_q;
    logic [`EX_DATA_W-1:0] lo_q;
    logic [`EX_DATA_W-1:0] wdata_d;
    logic                  wreg_d;

    always_comb begin
        case (res_sel_i)
            RES_LOGIC, RES_SHIFT, RES_ARITH: wdata_d = alu_res_i;
            RES_MOVE: begin
                if (mf_hi_i) begin
                    wdata_d = hi_q;
                end else if (mf_lo_i) begin
                    wdata_d = lo_q;
                end else begin
                    wdata_d = reg1_i;       // MOVZ and MOVN
                end
            end
            RES_MUL: wdata_d = product_i[`EX_DATA_W-1:0];
            default: wdata_d = '0;
        endcase
    end

    // Trapped overflow cancels the write
    assign wreg_d = wreg_i && !(ovf_i && ovf_trap_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wreg_o  <= 1'b0;
            waddr_o <= '0;
            wdata_o <= '0;
        end else begin
            wreg_o  <= wreg_d;
            waddr_o <= waddr_i;
            wdata_o <= wdata_d;
        end
    end

    // HI/LO written on the same edge as the result
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            case (hilo_wr_i)
                HILO_PRODUCT: begin
                    hi_q <= product_i[2*`EX_DATA_W-1:`EX_DATA_W];
                    lo_q <= product_i[`EX_DATA_W-1:0];
                end
                HILO_HI: hi_q <= reg1_i;
                HILO_LO: lo_q <= reg1_i;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ovf_i && ovf_trap_i) |=> !wreg_o)
        else $error("ex_result: register write not cancelled after overflow");

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  alu_op_e                aluop_i,
    input  logic [`EX_DATA_W-1:0]  reg1_data_i,    // rs
    input  logic [`EX_DATA_W-1:0]  reg2_data_i,    // rt
    input  logic [`EX_ADDR_W-1:0]  waddr_i,
    input  logic                   wreg_i,
    output logic                   wreg_o,
    output logic [`EX_ADDR_W-1:0]  waddr_o,
    output logic [`EX_DATA_W-1:0]  wdata_o
);

    res_sel_e                res_sel;
    alu_op_e                 alu_fn;
    hilo_wr_e                hilo_wr;
    logic                    sub_en;
    logic                    cmp_signed;
    logic                    cnt_ones;
    logic                    ovf_trap;
    logic                    mul_signed;
    logic                    mf_hi;
    logic                    mf_lo;
    logic                    ovf;
    logic [`EX_DATA_W-1:0]   alu_res;
    logic [2*`EX_DATA_W-1:0] product;

    ex_decode u_decode (
        .aluop_i      (aluop_i),
        .res_sel_o    (res_sel),
        .alu_fn_o     (alu_fn),
        .sub_en_o     (sub_en),
        .cmp_signed_o (cmp_signed),
        .cnt_ones_o   (cnt_ones),
        .ovf_trap_o   (ovf_trap),
        .mul_signed_o (mul_signed),
        .mf_hi_o      (mf_hi),
        .mf_lo_o      (mf_lo),
        .hilo_wr_o    (hilo_wr)
    );

    ex_alu u_alu (
        .alu_fn_i     (alu_fn),
        .reg1_i       (reg1_data_i),
        .reg2_i       (reg2_data_i),
        .sub_en_i     (sub_en),
        .cmp_signed_i (cmp_signed),
        .cnt_ones_i   (cnt_ones),
        .alu_res_o    (alu_res),
        .ovf_o        (ovf)
    );

    ex_mul u_mul (
        .reg1_i       (reg1_data_i),
        .reg2_i       (reg2_data_i),
        .mul_signed_i (mul_signed),
        .product_o    (product)
    );

    ex_result u_result (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .res_sel_i    (res_sel),
        .alu_res_i    (alu_res),
        .product_i    (product),
        .reg1_i       (reg1_data_i),
        .ovf_i        (ovf),
        .ovf_trap_i   (ovf_trap),
        .hilo_wr_i    (hilo_wr),
        .mf_hi_i      (mf_hi),
        .mf_lo_i      (mf_lo),
        .wreg_i       (wreg_i),
        .waddr_i      (waddr_i),
        .wreg_o       (wreg_o),
        .waddr_o      (waddr_o),
        .wdata_o      (wdata_o)
    );

endmodule

// File: testbench/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int RST_CYCLES = 10;
    localparam int N_RAND     = 8;
    localparam int DRAIN      = 2;      // Idle issues that flush the last check of a test
    localparam int TOTAL_OPS  = (1 + DRAIN) + (7*N_RAND + 4 + DRAIN) + (8 + 2*N_RAND + DRAIN)
                              + (12 + 2*N_RAND + DRAIN) + (4 + 4*N_RAND + DRAIN);
    localparam int MAX_CYCLES = 2*TOTAL_OPS + RST_CYCLES;

    logic                   clk_i;
    logic                   arst_n_i;
    alu_op_e                aluop_i;
    logic [`EX_DATA_W-1:0]  reg1_data_i;
    logic [`EX_DATA_W-1:0]  reg2_data_i;
    logic [`EX_ADDR_W-1:0]  waddr_i;
    logic                   wreg_i;
    logic                   wreg_o;
    logic [`EX_ADDR_W-1:0]  waddr_o;
    logic [`EX_DATA_W-1:0]  wdata_o;

    // Reference model state one cycle behind the inputs
    logic                   exp_wreg;
    logic [`EX_ADDR_W-1:0]  exp_waddr;
    logic [`EX_DATA_W-1:0]  exp_wdata;
    logic [`EX_DATA_W-1:0]  ref_hi;
    logic [`EX_DATA_W-1:0]  ref_lo;

    int err_cnt   = 0;
    int test_cnt  = 0;
    int test_err  = 0;
    int cycle_cnt = 0;

    alu_op_e bit_ops [7] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};

    ex_stage dut0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .aluop_i     (aluop_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .waddr_i     (waddr_i),
        .wreg_i      (wreg_i),
        .wreg_o      (wreg_o),
        .waddr_o     (waddr_o),
        .wdata_o     (wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Count of equal bits from the MSB down
    function automatic logic [`EX_DATA_W-1:0] lead_count(logic [`EX_DATA_W-1:0] w, logic val);
        logic [`EX_DATA_W-1:0] n;
        logic                  run;
        n   = '0;
        run = 1'b1;
        for (int i = `EX_DATA_W-1; i >= 0; i--) begin
            run = run && (w[i] == val);
            if (run) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    function automatic logic [2*`EX_DATA_W-1:0] signed_product(logic [`EX_DATA_W-1:0] a,
                                                               logic [`EX_DATA_W-1:0] b);
        return $signed({{`EX_DATA_W{a[`EX_DATA_W-1]}}, a}) *
               $signed({{`EX_DATA_W{b[`EX_DATA_W-1]}}, b});
    endfunction

    // Signed result outside the 32-bit range for ADD and SUB
    function automatic logic trap_on_ovf(alu_op_e op, logic [`EX_DATA_W-1:0] a,
                                         logic [`EX_DATA_W-1:0] b);
        logic [`EX_DATA_W:0] s;
        case (op)
            OP_ADD:  s = {a[`EX_DATA_W-1], a} + {b[`EX_DATA_W-1], b};
            OP_SUB:  s = {a[`EX_DATA_W-1], a} - {b[`EX_DATA_W-1], b};
            default: s = '0;
        endcase
        return s[`EX_DATA_W] != s[`EX_DATA_W-1];
    endfunction

    function automatic logic [`EX_DATA_W-1:0] ref_wdata(alu_op_e op,
            logic [`EX_DATA_W-1:0] rs, logic [`EX_DATA_W-1:0] rt,
            logic [`EX_DATA_W-1:0] hi, logic [`EX_DATA_W-1:0] lo);
        logic [`EX_SHAMT_W-1:0]  sa;
        logic [2*`EX_DATA_W-1:0] p;
        logic [`EX_DATA_W-1:0]   r;
        sa = rs[`EX_SHAMT_W-1:0];
        p  = signed_product(rs, rt);
        case (op)
            OP_AND:           r = rs & rt;
            OP_OR:            r = rs | rt;
            OP_XOR:           r = rs ^ rt;
            OP_NOR:           r = ~(rs | rt);
            OP_SLL:           r = rt << sa;
            OP_SRL:           r = rt >> sa;
            OP_SRA:           r = $unsigned($signed(rt) >>> sa);
            OP_ADD, OP_ADDU:  r = rs + rt;
            OP_SUB, OP_SUBU:  r = rs - rt;
            OP_SLT:           r = {{(`EX_DATA_W-1){1'b0}}, $signed(rs) < $signed(rt)};
            OP_SLTU:          r = {{(`EX_DATA_W-1){1'b0}}, rs < rt};
            OP_CLZ:           r = lead_count(rs, 1'b0);
            OP_CLO:           r = lead_count(rs, 1'b1);
            OP_MOVZ, OP_MOVN: r = rs;
            OP_MFHI:          r = hi;
            OP_MFLO:          r = lo;
            OP_MUL:           r = p[`EX_DATA_W-1:0];
            default:          r = '0;   // Ops without a register result
        endcase
        return r;
    endfunction

    function automatic logic [`EX_DATA_W-1:0] rand_small();
        logic [`EX_DATA_W-1:0] r;
        r = $urandom;
        return {{3{r[28]}}, r[28:0]};   // Sums of two stay in range
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_wreg  <= 1'b0;
            exp_waddr <= '0;
            exp_wdata <= '0;
            ref_hi    <= '0;
            ref_lo    <= '0;
        end else begin
            exp_wreg  <= wreg_i && !trap_on_ovf(aluop_i, reg1_data_i, reg2_data_i);
            exp_waddr <= waddr_i;
            exp_wdata <= ref_wdata(aluop_i, reg1_data_i, reg2_data_i, ref_hi, ref_lo);
            case (aluop_i)
                OP_MTHI:  ref_hi <= reg1_data_i;
                OP_MTLO:  ref_lo <= reg1_data_i;
                OP_MULT:  {ref_hi, ref_lo} <= signed_product(reg1_data_i, reg2_data_i);
                OP_MULTU: {ref_hi, ref_lo} <= {{`EX_DATA_W{1'b0}}, reg1_data_i} *
                                              {{`EX_DATA_W{1'b0}}, reg2_data_i};
                default:  ;
            endcase
        end
    end

    task automatic report_mismatch(string name, logic [31:0] exp_val, logic [31:0] act_val);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_val, act_val);
        err_cnt++;
    endtask

    assert property (@(posedge clk_i) !arst_n_i |-> !wreg_o)
        else report_mismatch("wreg_o", 32'd0, 32'($sampled(wreg_o)));

    assert property (@(posedge clk_i) !arst_n_i |-> (wdata_o == '0))
        else report_mismatch("wdata_o", 32'd0, $sampled(wdata_o));

    assert property (@(posedge clk_i) disable iff (!arst_n_i) wreg_o == exp_wreg)
        else report_mismatch("wreg_o", 32'($sampled(exp_wreg)), 32'($sampled(wreg_o)));

    assert property (@(posedge clk_i) disable iff (!arst_n_i) waddr_o == exp_waddr)
        else report_mismatch("waddr_o", 32'($sampled(exp_waddr)), 32'($sampled(waddr_o)));

    assert property (@(posedge clk_i) disable iff (!arst_n_i) wdata_o == exp_wdata)
        else report_mismatch("wdata_o", $sampled(exp_wdata), $sampled(wdata_o));

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout, run went past %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic issue(alu_op_e op, logic [`EX_DATA_W-1:0] rs, logic [`EX_DATA_W-1:0] rt,
                         logic wr);
        logic [31:0] r;
        r = $urandom;
        @(posedge clk_i);
        aluop_i     <= op;
        reg1_data_i <= rs;
        reg2_data_i <= rt;
        waddr_i     <= r[`EX_ADDR_W-1:0];
        wreg_i      <= wr;
    endtask

    task automatic finish_test(string name);
        repeat (DRAIN) issue(OP_NOP, '0, '0, 1'b0);
        @(negedge clk_i);                   // Last checks have fired
        test_cnt++;
        $display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    initial begin
        logic [`EX_DATA_W-1:0] a;
        logic [`EX_DATA_W-1:0] b;
        void'($urandom(32'h3554));
        arst_n_i    = 1'b0;
        aluop_i     = OP_NOP;
        reg1_data_i = '0;
        reg2_data_i = '0;
        waddr_i     = '0;
        wreg_i      = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;

        issue(OP_MFHI, $urandom, $urandom, 1'b1);   // HI still zero
        finish_test("reset");

        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < 7; k++) begin
                issue(bit_ops[k], $urandom, $urandom, 1'b1);
            end
        end
        for (int i = 0; i < 4; i++) begin
            issue(OP_SRA, $urandom, $urandom | 32'h8000_0000, 1'b1);
        end
        finish_test("logic and shifts");

        issue(OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 1'b1);
        issue(OP_ADD,  32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue(OP_SUB,  32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(OP_SUB,  32'h7fff_ffff, 32'hffff_ffff, 1'b1);
        issue(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        issue(OP_ADDU, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue(OP_SUBU, 32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(OP_SUBU, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
        for (int i = 0; i < N_RAND; i++) begin
            issue(OP_ADD, rand_small(), rand_small(), 1'b1);
            issue(OP_SUB, rand_small(), rand_small(), 1'b1);
        end
        finish_test("add and subtract");

        for (int i = 0; i < 4; i++) begin
            a = $urandom;
            b = $urandom;
            a[`EX_DATA_W-1] = i[0];         // Opposite signs
            b[`EX_DATA_W-1] = !i[0];
            issue(OP_SLT, a, b, 1'b1);
            issue(OP_SLTU, a, b, 1'b1);
        end
        issue(OP_CLZ, 32'h0, '0, 1'b1);
        issue(OP_CLO, 32'h0, '0, 1'b1);
        issue(OP_CLZ, 32'hffff_ffff, '0, 1'b1);
        issue(OP_CLO, 32'hffff_ffff, '0, 1'b1);
        for (int i = 0; i < N_RAND; i++) begin
            a = $urandom >> (i*4);          // Spread of leading counts
            issue(OP_CLZ, a, '0, 1'b1);
            issue(OP_CLO, ~a, '0, 1'b1);
        end
        finish_test("compares and bit counts");

        a = $urandom;
        b = $urandom;
        issue(OP_MTHI, a, '0, 1'b0);
        issue(OP_MTLO, b, '0, 1'b0);
        issue(OP_MFHI, '0, '0, 1'b1);
        issue(OP_MFLO, '0, '0, 1'b1);
        for (int i = 0; i < N_RAND; i++) begin
            issue(i[0] ? OP_MULTU : OP_MULT, $urandom, $urandom, 1'b0);
            issue(OP_MFHI, '0, '0, 1'b1);
            issue(OP_MFLO, '0, '0, 1'b1);
        end
        for (int i = 0; i < N_RAND; i++) begin
            issue(OP_MUL, $urandom, $urandom, 1'b1);
        end
        finish_test("HI/LO and multiplies");

        $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_result.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ex_stage

if ! verilator --binary --timing --assert -f files.f --top-module "$TOP" --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/V"$TOP" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "No errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
